/* common/fec_pkg.sv */
`default_nettype none

package fec_pkg;

    // ========================================
    // Code constants
    // ========================================
    localparam int SYM_SIZE = 8;
    localparam int RS_K     = 8;
    localparam int RS_2T    = 2;
    localparam int NUM_H    = RS_K + RS_2T;

    // Primitive polynomial x^8 + x^4 + x^3 + x^2 + 1
    localparam logic [8:0] GF_POLY = 9'h11D;

    typedef logic [SYM_SIZE-1:0]       sym_t;
    typedef logic [3:0]                loc_t;
    typedef logic [RS_K*SYM_SIZE-1:0]  data_blk_t;
    typedef logic [NUM_H*SYM_SIZE-1:0] cw_t;
    typedef logic [4:0]                wb_adr_t;
    typedef logic [31:0]               wb_dat_t;

    // ========================================
    // Register map (word addresses)
    // ========================================
    localparam wb_adr_t ADR_DATA_IN   = 5'd0;
    localparam wb_adr_t ADR_ERASE_LOC = 5'd8;
    localparam wb_adr_t ADR_ERASE_PAT = 5'd9;
    localparam wb_adr_t ADR_STRAY_LOC = 5'd10;
    localparam wb_adr_t ADR_STRAY_PAT = 5'd11;
    localparam wb_adr_t ADR_LAUNCH    = 5'd12;
    localparam wb_adr_t ADR_STATUS    = 5'd13;
    localparam wb_adr_t ADR_RELEASE   = 5'd14;
    localparam wb_adr_t ADR_DATA_OUT  = 5'd16;

    // Bit 0 is stage one valid, bit 1 is stage two valid
    typedef enum logic [1:0] {
        DEC_IDLE = 2'b00,
        DEC_S1   = 2'b01,
        DEC_S2   = 2'b10,
        DEC_FULL = 2'b11
    } dec_state_e;

    // Shift-and-add multiply with reduction
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        sym_t acc;
        sym_t x;
        acc = '0;
        x   = a;
        for (int i = 0; i < SYM_SIZE; i++) begin
            if (b[i])
                acc = acc ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? GF_POLY[7:0] : 8'h00);
        end
        return acc;
    endfunction

    // alpha^i with alpha = 2
    function automatic sym_t gf_weight(input int i);
        sym_t w;
        w = 8'h01;
        for (int k = 0; k < NUM_H; k++) begin
            if (k < i)
                w = gf_mul(w, 8'h02);
        end
        return w;
    endfunction

endpackage

`default_nettype wire

/* fec_codec/fec_encode.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_encode (
    input  wire                 clk,
    input  wire                 rst_n,
    // From the front end
    input  fec_pkg::data_blk_t  in_data,
    input  fec_pkg::loc_t       in_erase_loc,
    input  fec_pkg::sym_t       in_erase_pat,
    input  fec_pkg::loc_t       in_stray_loc,
    input  fec_pkg::sym_t       in_stray_pat,
    input  wire                 in_valid,
    output logic                in_ready,
    // Codeword towards the channel model
    output fec_pkg::cw_t        out_cw,
    output fec_pkg::loc_t       out_erase_loc,
    output fec_pkg::sym_t       out_erase_pat,
    output fec_pkg::loc_t       out_stray_loc,
    output fec_pkg::sym_t       out_stray_pat,
    output logic                out_valid,
    input  wire                 out_ready
);
    import fec_pkg::*;

    sym_t par_plain;
    sym_t par_wgt;

    // Plain parity and alpha-weighted parity over the data symbols
    always_comb begin
        sym_t d;
        par_plain = '0;
        par_wgt   = '0;
        for (int i = 0; i < RS_K; i++) begin
            d         = in_data[i*SYM_SIZE +: SYM_SIZE];
            par_plain = par_plain ^ d;
            par_wgt   = par_wgt ^ gf_mul(gf_weight(i), d);
        end
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_cw        <= {par_wgt, par_plain, in_data};
            out_erase_loc <= in_erase_loc;
            out_erase_pat <= in_erase_pat;
            out_stray_loc <= in_stray_loc;
            out_stray_pat <= in_stray_pat;
        end
    end

endmodule

`default_nettype wire

/* fec_codec/fec_err_inject.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_err_inject (
    input  wire             clk,
    input  wire             rst_n,
    // Clean codeword with corruption settings
    input  fec_pkg::cw_t    in_cw,
    input  fec_pkg::loc_t   in_erase_loc,
    input  fec_pkg::sym_t   in_erase_pat,
    input  fec_pkg::loc_t   in_stray_loc,
    input  fec_pkg::sym_t   in_stray_pat,
    input  wire             in_valid,
    output logic            in_ready,
    // Corrupted codeword, only the erasure is marked
    output fec_pkg::cw_t    out_cw,
    output fec_pkg::loc_t   out_erase_loc,
    output logic            out_valid,
    input  wire             out_ready
);
    import fec_pkg::*;

    cw_t bad_cw;

    // Locations at NUM_H and above match no position and leave the word alone
    always_comb begin
        bad_cw = in_cw;
        for (int i = 0; i < NUM_H; i++) begin
            if (loc_t'(i) == in_erase_loc)
                bad_cw[i*SYM_SIZE +: SYM_SIZE] = bad_cw[i*SYM_SIZE +: SYM_SIZE] ^ in_erase_pat;
            if (loc_t'(i) == in_stray_loc)
                bad_cw[i*SYM_SIZE +: SYM_SIZE] = bad_cw[i*SYM_SIZE +: SYM_SIZE] ^ in_stray_pat;
        end
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_cw        <= bad_cw;
            out_erase_loc <= in_erase_loc;
        end
    end

endmodule

`default_nettype wire

/* fec_codec/fec_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_decode (
    input  wire                 clk,
    input  wire                 rst_n,
    input  fec_pkg::cw_t        in_cw,
    input  fec_pkg::loc_t       in_erase_loc,
    input  wire                 in_valid,
    output logic                in_ready,
    output fec_pkg::data_blk_t  out_data,
    output logic                out_check_error,
    output logic                out_valid,
    input  wire                 out_ready,
    output logic                busy
);
    import fec_pkg::*;

    dec_state_e state;
    logic       s1_valid;
    logic       s2_ready;
    logic       s1_next;
    logic       s2_next;
    cw_t        rec_cw;
    cw_t        s1_cw;
    loc_t       s1_erase_loc;
    logic       chk_err;

    assign s1_valid  = (state == DEC_S1) || (state == DEC_FULL);
    assign out_valid = (state == DEC_S2) || (state == DEC_FULL);
    assign busy      = (state != DEC_IDLE);

    // Each stage can take a new block when its slot drains this cycle
    assign s2_ready = !out_valid || out_ready;
    assign in_ready = !s1_valid || s2_ready;
    assign s1_next  = in_ready ? in_valid : s1_valid;
    assign s2_next  = s2_ready ? s1_valid : out_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= DEC_IDLE;
        else
            state <= dec_state_e'({s2_next, s1_next});
    end

    // ========================================
    // Stage one: erasure fill
    // ========================================
    always_comb begin
        sym_t fill;
        fill = '0;
        // Data and plain parity XOR to zero on a clean word
        for (int i = 0; i <= RS_K; i++) begin
            if (loc_t'(i) != in_erase_loc)
                fill = fill ^ in_cw[i*SYM_SIZE +: SYM_SIZE];
        end
        rec_cw = in_cw;
        for (int i = 0; i < RS_K; i++) begin
            if (loc_t'(i) == in_erase_loc)
                rec_cw[i*SYM_SIZE +: SYM_SIZE] = fill;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_cw        <= rec_cw;
            s1_erase_loc <= in_erase_loc;
        end
    end

    // ========================================
    // Stage two: parity check
    // ========================================
    always_comb begin
        sym_t d;
        sym_t p_plain;
        sym_t p_wgt;
        p_plain = '0;
        p_wgt   = '0;
        for (int i = 0; i < RS_K; i++) begin
            d       = s1_cw[i*SYM_SIZE +: SYM_SIZE];
            p_plain = p_plain ^ d;
            p_wgt   = p_wgt ^ gf_mul(gf_weight(i), d);
        end
        // An erased parity symbol carries no information
        chk_err = ((p_plain != s1_cw[RS_K*SYM_SIZE +: SYM_SIZE])
                   && (s1_erase_loc != loc_t'(RS_K)))
               || ((p_wgt != s1_cw[(RS_K+1)*SYM_SIZE +: SYM_SIZE])
                   && (s1_erase_loc != loc_t'(RS_K+1)));
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s2_ready) begin
            out_data        <= s1_cw[RS_K*SYM_SIZE-1:0];
            out_check_error <= chk_err;
        end
    end

endmodule

`default_nettype wire

/* rtl/fec_wb_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_wb_frontend (
    input  wire                 clk,
    input  wire                 rst_n,
    // Wishbone classic slave
    input  wire                 cyc,
    input  wire                 stb,
    input  wire                 we,
    input  fec_pkg::wb_adr_t    adr,
    input  fec_pkg::wb_dat_t    dat_w,
    output fec_pkg::wb_dat_t    dat_r,
    output logic                ack,
    // Launch stream towards the encoder
    output fec_pkg::data_blk_t  out_data,
    output fec_pkg::loc_t       out_erase_loc,
    output fec_pkg::sym_t       out_erase_pat,
    output fec_pkg::loc_t       out_stray_loc,
    output fec_pkg::sym_t       out_stray_pat,
    output logic                out_valid,
    input  wire                 out_ready,
    // Result side
    input  fec_pkg::data_blk_t  res_data,
    input  wire                 res_valid,
    input  wire                 res_check_error,
    input  wire                 chain_busy,
    output logic                res_release
);
    import fec_pkg::*;

    logic      access;
    logic      wr_access;
    logic      is_launch;
    data_blk_t data_q;
    loc_t      erase_loc_q;
    sym_t      erase_pat_q;
    loc_t      stray_loc_q;
    sym_t      stray_pat_q;

    // A bus cycle is pending until it has been acked
    assign access    = cyc && stb && !ack;
    assign wr_access = access && we;
    assign is_launch = (adr == ADR_LAUNCH);

    // Launch presents the held registers; the master keeps stb up while stalled
    assign out_valid     = wr_access && is_launch;
    assign out_data      = data_q;
    assign out_erase_loc = erase_loc_q;
    assign out_erase_pat = erase_pat_q;
    assign out_stray_loc = stray_loc_q;
    assign out_stray_pat = stray_pat_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            res_release <= 1'b0;
        end else begin
            ack         <= access && !(we && is_launch && !out_ready);
            res_release <= wr_access && (adr == ADR_RELEASE);
        end
    end

    // Data symbols hold whatever software last wrote
    always_ff @(posedge clk) begin
        if (wr_access && (adr[4:3] == ADR_DATA_IN[4:3]))
            data_q[adr[2:0]*SYM_SIZE +: SYM_SIZE] <= dat_w[SYM_SIZE-1:0];
    end

    // Corruption registers default to no erasure and no stray error
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            erase_loc_q <= '1;
            erase_pat_q <= '0;
            stray_loc_q <= '1;
            stray_pat_q <= '0;
        end else if (wr_access) begin
            case (adr)
                ADR_ERASE_LOC: erase_loc_q <= dat_w[3:0];
                ADR_ERASE_PAT: erase_pat_q <= dat_w[SYM_SIZE-1:0];
                ADR_STRAY_LOC: stray_loc_q <= dat_w[3:0];
                ADR_STRAY_PAT: stray_pat_q <= dat_w[SYM_SIZE-1:0];
                default: ;
            endcase
        end
    end

    // Read mux, sampled by the master while ack is high
    always_comb begin
        dat_r = '0;
        if (adr[4] == ADR_DATA_OUT[4])
            dat_r[SYM_SIZE-1:0] = res_data[adr[2:0]*SYM_SIZE +: SYM_SIZE];
        else if (adr == ADR_STATUS)
            dat_r[2:0] = {chain_busy, res_check_error, res_valid};
    end

endmodule

`default_nettype wire

/* rtl/fec_result_store.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_result_store (
    input  wire                 clk,
    input  wire                 rst_n,
    // Decoded stream
    input  fec_pkg::data_blk_t  in_data,
    input  wire                 in_check_error,
    input  wire                 in_valid,
    output logic                in_ready,
    // Software side
    input  wire                 res_release,
    output fec_pkg::data_blk_t  res_data,
    output logic                res_valid,
    output logic                res_check_error
);
    import fec_pkg::*;

    logic capture;

    // Single slot, the chain stalls behind a held result
    assign in_ready = !res_valid;
    assign capture  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid       <= 1'b0;
            res_check_error <= 1'b0;
        end else if (capture) begin
            res_valid       <= 1'b1;
            res_check_error <= in_check_error;
        end else if (res_release) begin
            res_valid       <= 1'b0;
            res_check_error <= 1'b0;
        end
    end

    // Software reads zeros until the first block lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_data <= data_blk_t'(0);
        else if (capture)
            res_data <= in_data;
    end

endmodule

`default_nettype wire

/* rtl/fec_loopback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_loopback_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cyc,
    input  wire                 stb,
    input  wire                 we,
    input  fec_pkg::wb_adr_t    adr,
    input  fec_pkg::wb_dat_t    dat_w,
    output fec_pkg::wb_dat_t    dat_r,
    output logic                ack
);
    import fec_pkg::*;

    // ========================================
    // Stream wiring
    // ========================================
    data_blk_t fe_data;
    loc_t      fe_erase_loc;
    sym_t      fe_erase_pat;
    loc_t      fe_stray_loc;
    sym_t      fe_stray_pat;
    logic      fe_valid;
    logic      fe_ready;

    cw_t       enc_cw;
    loc_t      enc_erase_loc;
    sym_t      enc_erase_pat;
    loc_t      enc_stray_loc;
    sym_t      enc_stray_pat;
    logic      enc_valid;
    logic      enc_ready;

    cw_t       inj_cw;
    loc_t      inj_erase_loc;
    logic      inj_valid;
    logic      inj_ready;

    data_blk_t dec_data;
    logic      dec_check_error;
    logic      dec_valid;
    logic      dec_ready;
    logic      dec_busy;

    data_blk_t res_data;
    logic      res_valid;
    logic      res_check_error;
    logic      res_release;
    logic      chain_busy;

    // Anything between launch and the result store
    assign chain_busy = enc_valid || inj_valid || dec_busy;

    fec_wb_frontend fec_wb_frontend_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .cyc             (cyc),
        .stb             (stb),
        .we              (we),
        .adr             (adr),
        .dat_w           (dat_w),
        .dat_r           (dat_r),
        .ack             (ack),
        .out_data        (fe_data),
        .out_erase_loc   (fe_erase_loc),
        .out_erase_pat   (fe_erase_pat),
        .out_stray_loc   (fe_stray_loc),
        .out_stray_pat   (fe_stray_pat),
        .out_valid       (fe_valid),
        .out_ready       (fe_ready),
        .res_data        (res_data),
        .res_valid       (res_valid),
        .res_check_error (res_check_error),
        .chain_busy      (chain_busy),
        .res_release     (res_release)
    );

    fec_encode fec_encode_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_data       (fe_data),
        .in_erase_loc  (fe_erase_loc),
        .in_erase_pat  (fe_erase_pat),
        .in_stray_loc  (fe_stray_loc),
        .in_stray_pat  (fe_stray_pat),
        .in_valid      (fe_valid),
        .in_ready      (fe_ready),
        .out_cw        (enc_cw),
        .out_erase_loc (enc_erase_loc),
        .out_erase_pat (enc_erase_pat),
        .out_stray_loc (enc_stray_loc),
        .out_stray_pat (enc_stray_pat),
        .out_valid     (enc_valid),
        .out_ready     (enc_ready)
    );

    fec_err_inject fec_err_inject_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_cw         (enc_cw),
        .in_erase_loc  (enc_erase_loc),
        .in_erase_pat  (enc_erase_pat),
        .in_stray_loc  (enc_stray_loc),
        .in_stray_pat  (enc_stray_pat),
        .in_valid      (enc_valid),
        .in_ready      (enc_ready),
        .out_cw        (inj_cw),
        .out_erase_loc (inj_erase_loc),
        .out_valid     (inj_valid),
        .out_ready     (inj_ready)
    );

    fec_decode fec_decode_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_cw           (inj_cw),
        .in_erase_loc    (inj_erase_loc),
        .in_valid        (inj_valid),
        .in_ready        (inj_ready),
        .out_data        (dec_data),
        .out_check_error (dec_check_error),
        .out_valid       (dec_valid),
        .out_ready       (dec_ready),
        .busy            (dec_busy)
    );

    fec_result_store fec_result_store_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_data         (dec_data),
        .in_check_error  (dec_check_error),
        .in_valid        (dec_valid),
        .in_ready        (dec_ready),
        .res_release     (res_release),
        .res_data        (res_data),
        .res_valid       (res_valid),
        .res_check_error (res_check_error)
    );

endmodule

`default_nettype wire

/* testbench/fec_loopback_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_loopback_chk (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     cyc,
    input  wire                     stb,
    input  wire                     ack,
    input  wire                     fe_valid,
    input  wire                     fe_ready,
    input  fec_pkg::data_blk_t      fe_data,
    input  wire                     enc_valid,
    input  wire                     enc_ready,
    input  fec_pkg::cw_t            enc_cw,
    input  wire                     inj_valid,
    input  wire                     inj_ready,
    input  fec_pkg::cw_t            inj_cw,
    input  wire                     dec_ready,
    input  fec_pkg::data_blk_t      dec_data,
    input  wire                     dec_check_error,
    input  fec_pkg::dec_state_e     dec_state
);
    import fec_pkg::*;

    // ========================================
    // Wishbone handshake
    // ========================================
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else $error("ack held for more than one cycle");

    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(cyc && stb))
        else $error("ack without a preceding strobe");

    // ========================================
    // Stream stability under a stall
    // ========================================
    fe_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (fe_valid && !fe_ready) |=> (fe_valid && $stable(fe_data)))
        else $error("launch data changed while stalled");

    enc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (enc_valid && !enc_ready) |=> (enc_valid && $stable(enc_cw)))
        else $error("encoder output changed while stalled");

    inj_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (inj_valid && !inj_ready) |=> (inj_valid && $stable(inj_cw)))
        else $error("injector output changed while stalled");

    // Decoded block waits unchanged while the store refuses
    dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((dec_state == DEC_S2 || dec_state == DEC_FULL) && !dec_ready)
        |=> ((dec_state == DEC_S2 || dec_state == DEC_FULL)
             && $stable(dec_data) && $stable(dec_check_error)))
        else $error("decoder output changed while stalled");

endmodule

bind fec_loopback_top fec_loopback_chk fec_loopback_chk_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .cyc             (cyc),
    .stb             (stb),
    .ack             (ack),
    .fe_valid        (fe_valid),
    .fe_ready        (fe_ready),
    .fe_data         (fe_data),
    .enc_valid       (enc_valid),
    .enc_ready       (enc_ready),
    .enc_cw          (enc_cw),
    .inj_valid       (inj_valid),
    .inj_ready       (inj_ready),
    .inj_cw          (inj_cw),
    .dec_ready       (dec_ready),
    .dec_data        (dec_data),
    .dec_check_error (dec_check_error),
    .dec_state       (fec_decode_inst.state)
);

`default_nettype wire

/* testbench/fec_loopback_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fec_loopback_tb;
    import fec_pkg::*;

    localparam int ACK_TIMEOUT = 64;
    localparam int POLL_LIMIT  = 40;
    localparam int RUN_LIMIT   = 400000;

    logic    clk;
    logic    rst_n;
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat_w;
    wb_dat_t dat_r;
    logic    ack;

    // Expected results in launch order
    data_blk_t exp_data_q[$];
    logic      exp_err_q[$];

    fec_loopback_top fec_loopback_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #2 clk = ~clk;

    // ========================================
    // Reporting
    // ========================================
    task automatic fail_run(input string reason);
        $display("ERROR t=%0t %s", $time, reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    // Carry-less product, then reduction by x^8+x^4+x^3+x^2+1
    function automatic sym_t gf_product(input sym_t a, input sym_t b);
        logic [14:0] prod;
        prod = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                prod = prod ^ (15'(a) << i);
        end
        for (int i = 14; i >= 8; i--) begin
            if (prod[i])
                prod = prod ^ (15'h11D << (i - 8));
        end
        return prod[7:0];
    endfunction

    function automatic sym_t alpha_pow(input int n);
        sym_t w;
        w = 8'h01;
        repeat (n) w = gf_product(w, 8'h02);
        return w;
    endfunction

    task automatic model_block(input data_blk_t data, input loc_t eloc, input sym_t epat,
                               input loc_t sloc, input sym_t spat);
        cw_t  cw;
        sym_t plain;
        sym_t wgt;
        sym_t fill;
        logic stray_hit;
        plain = '0;
        wgt   = '0;
        for (int i = 0; i < 8; i++) begin
            plain = plain ^ data[i*8 +: 8];
            wgt   = wgt ^ gf_product(alpha_pow(i), data[i*8 +: 8]);
        end
        cw = {wgt, plain, data};
        // Channel corruption
        for (int i = 0; i < 10; i++) begin
            if (loc_t'(i) == eloc)
                cw[i*8 +: 8] = cw[i*8 +: 8] ^ epat;
            if (loc_t'(i) == sloc)
                cw[i*8 +: 8] = cw[i*8 +: 8] ^ spat;
        end
        // Erased data symbol rebuilt from the others and the plain parity
        if (eloc < 8) begin
            fill = '0;
            for (int i = 0; i <= 8; i++) begin
                if (loc_t'(i) != eloc)
                    fill = fill ^ cw[i*8 +: 8];
            end
            cw[eloc*8 +: 8] = fill;
        end
        stray_hit = (sloc < 10) && (spat != 8'h00);
        exp_data_q.push_back(stray_hit ? cw[63:0] : data);
        exp_err_q.push_back(stray_hit && (sloc != eloc));
    endtask

    // ========================================
    // Wishbone master
    // ========================================
    task automatic bus_cycle(input logic wr, input wb_adr_t a, input wb_dat_t wd,
                             output wb_dat_t rd);
        int waited;
        waited = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = wd;
        @(negedge clk);
        while (!ack) begin
            waited++;
            if (waited > ACK_TIMEOUT)
                fail_run("no ack on the Wishbone bus");
            @(negedge clk);
        end
        rd  = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_write(input wb_adr_t a, input wb_dat_t wd);
        wb_dat_t unused;
        bus_cycle(1'b1, a, wd, unused);
    endtask

    task automatic bus_read(input wb_adr_t a, output wb_dat_t rd);
        bus_cycle(1'b0, a, '0, rd);
    endtask

    // Polls status until result_valid reads 1
    task automatic wait_result(output wb_dat_t st);
        int polls;
        polls = 0;
        bus_read(ADR_STATUS, st);
        while (!st[0]) begin
            polls++;
            if (polls > POLL_LIMIT)
                fail_run("result_valid never came up");
            bus_read(ADR_STATUS, st);
        end
    endtask

    task automatic send_block(input data_blk_t data, input loc_t eloc, input sym_t epat,
                              input loc_t sloc, input sym_t spat);
        for (int i = 0; i < 8; i++)
            bus_write(wb_adr_t'(ADR_DATA_IN + i), wb_dat_t'(data[i*8 +: 8]));
        bus_write(ADR_ERASE_LOC, wb_dat_t'(eloc));
        bus_write(ADR_ERASE_PAT, wb_dat_t'(epat));
        bus_write(ADR_STRAY_LOC, wb_dat_t'(sloc));
        bus_write(ADR_STRAY_PAT, wb_dat_t'(spat));
        model_block(data, eloc, epat, sloc, spat);
        bus_write(ADR_LAUNCH, '0);
    endtask

    task automatic collect_result();
        wb_dat_t   st;
        wb_dat_t   rd;
        data_blk_t got;
        data_blk_t exp_d;
        logic      exp_e;
        wait_result(st);
        for (int i = 0; i < 8; i++) begin
            bus_read(wb_adr_t'(ADR_DATA_OUT + i), rd);
            got[i*8 +: 8] = rd[7:0];
        end
        if (exp_data_q.size() == 0)
            fail_run("result arrived with no block outstanding");
        exp_d = exp_data_q.pop_front();
        exp_e = exp_err_q.pop_front();
        check_value("res_data", got, exp_d);
        check_value("check_error", 64'(st[1]), 64'(exp_e));
        bus_write(ADR_RELEASE, '0);
    endtask

    task automatic expect_idle();
        wb_dat_t st;
        bus_read(ADR_STATUS, st);
        check_value("status", 64'(st), 64'd0);
    endtask

    task automatic run_block(input data_blk_t data, input loc_t eloc, input sym_t epat,
                             input loc_t sloc, input sym_t spat);
        send_block(data, eloc, epat, sloc, spat);
        collect_result();
        expect_idle();
    endtask

    function automatic data_blk_t random_block();
        return {$urandom(), $urandom()};
    endfunction

    function automatic sym_t random_pat();
        return sym_t'($urandom_range(1, 255));
    endfunction

    // Watchdog for the whole run
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        fail_run("simulation ran past its cycle limit");
    end

    initial begin
        wb_dat_t st;
        wb_dat_t rd;
        loc_t    eloc;
        loc_t    sloc;
        clk   = 1'b0;
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        void'($urandom(32'h31d2_031d));
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Reset state
        bus_read(ADR_STATUS, rd);
        check_value("status", 64'(rd), 64'd0);
        for (int i = 0; i < 8; i++) begin
            bus_read(wb_adr_t'(ADR_DATA_OUT + i), rd);
            check_value("dat_r", 64'(rd), 64'd0);
        end

        // Clean recovery of one erasure
        for (int n = 0; n < 200; n++)
            run_block(random_block(), loc_t'($urandom_range(0, 9)), random_pat(), 4'hF, 8'h00);

        // Erased parity symbols
        for (int n = 0; n < 8; n++)
            run_block(random_block(), loc_t'(8 + n % 2), random_pat(), 4'hF, 8'h00);

        // Stray error away from the erasure
        for (int n = 0; n < 40; n++) begin
            eloc = loc_t'($urandom_range(0, 9));
            sloc = loc_t'((int'(eloc) + 1 + int'($urandom_range(0, 8))) % 10);
            run_block(random_block(), eloc, random_pat(), sloc, random_pat());
        end
        // Stray error with nothing erased
        for (int n = 0; n < 20; n++) begin
            run_block(random_block(), loc_t'($urandom_range(10, 15)), random_pat(),
                      loc_t'($urandom_range(0, 9)), random_pat());
        end
        // Stray error on the erased symbol is absorbed
        for (int n = 0; n < 10; n++) begin
            eloc = loc_t'($urandom_range(0, 9));
            run_block(random_block(), eloc, random_pat(), eloc, random_pat());
        end

        // Back-pressure with the store held and every slot filled
        for (int r = 0; r < 3; r++) begin
            for (int b = 0; b < 5; b++) begin
                eloc = loc_t'($urandom_range(0, 9));
                sloc = (b == 2) ? loc_t'((int'(eloc) + 3) % 10) : 4'hF;
                send_block(random_block(), eloc, random_pat(), sloc, random_pat());
            end
            bus_read(ADR_STATUS, st);
            check_value("result_valid", 64'(st[0]), 64'd1);
            check_value("busy", 64'(st[2]), 64'd1);
            for (int b = 0; b < 5; b++)
                collect_result();
            expect_idle();
        end

        // Pass-through with no corruption at all
        for (int n = 0; n < 20; n++) begin
            run_block(random_block(), loc_t'($urandom_range(10, 15)), random_pat(),
                      loc_t'($urandom_range(10, 15)), random_pat());
        end

        if (exp_data_q.size() != 0) begin
            fail_run("blocks still outstanding at the end of the run");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
common/fec_pkg.sv
fec_codec/fec_encode.sv
fec_codec/fec_err_inject.sv
fec_codec/fec_decode.sv
rtl/fec_wb_frontend.sv
rtl/fec_result_store.sv
rtl/fec_loopback_top.sv
testbench/fec_loopback_chk.sv
testbench/fec_loopback_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the loopback testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

TOP=fec_loopback_tb
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module "$TOP" -Mdir obj_dir

./obj_dir/V"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
